/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_msx_mem \
   -f src.f --Mdir obj_dir -o tb_msx_mem

./obj_dir/tb_msx_mem > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASS" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

/* src.f */
verilog/msx_pkg.sv
verilog/msx2_ram_mapper.sv
verilog/cart_rom.sv
verilog/download.sv
verilog/dpram.sv
verilog/msx_slots.sv
verilog/msx_mem_top.sv
test/tb_msx_mem_assert.sv
test/tb_msx_mem.sv

/* test/tb_msx_mem.sv */
`timescale 1ns/1ps

module tb_msx_mem
   import msx_pkg::*;
();

   localparam int ROM_BYTES  = 256;
   localparam int ROM_START  = 'h3F80;
   localparam int CART_BYTES = 32768;
   // Every download byte and every read costs about two cycles
   localparam int TIMEOUT_CYCLES = 2 * (2 * ROM_BYTES + CART_BYTES) + 4000;

   logic       clk;
   logic       reset;
   cpu_bus_t   cpu;
   logic [7:0] cpu_din;
   logic [1:0] active_slot;
   msx_cfg_t   cfg;
   ioctl_t     ioctl;
   logic       need_reset;

   int         errors;
   int         checks;
   int         cycles = 0;
   logic [7:0] img [$];
   logic [7:0] rom_img [ROM_BYTES];

   msx_mem_top #(.MEM_AW(17), .BANK_W(2)) dut_i (
      .clk         (clk),
      .reset       (reset),
      .cpu         (cpu),
      .cpu_din     (cpu_din),
      .active_slot (active_slot),
      .cfg         (cfg),
      .ioctl       (ioctl),
      .need_reset  (need_reset)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST FAIL");
         $finish;
      end
   end

   function automatic block_t page_entry(slot_typ_t typ, logic [3:0] id);
      block_t b;
      b.typ      = typ;
      b.block_id = id;
      b.offset   = 2'd0;
      b.init     = 1'b1;
      return b;
   endfunction

   function automatic msx_cfg_t build_cfg();
      msx_cfg_t c;
      c = '0;
      c.slot_typ[0] = SLOT_TYP_ROM;
      c.slot_typ[1] = SLOT_TYP_EXPANDED;
      c.slot_typ[2] = SLOT_TYP_MSX2_RAM;
      c.slot_typ[3] = SLOT_TYP_CART;
      c.block_base[0] = 17'h00000;
      c.block_base[1] = 17'h04000;
      c.block_base[2] = 17'h08000;
      c.block_base[3] = 17'h0C000;
      c.block_base[4] = 17'h10000;
      // System ROM in pages 0 and 1
      c.mem_block[0][0][0] = page_entry(SLOT_TYP_ROM, 4'd0);
      c.mem_block[0][0][1] = page_entry(SLOT_TYP_ROM, 4'd1);
      // Two RAM subslots on page 2 of slot 1
      c.mem_block[1][0][2] = page_entry(SLOT_TYP_RAM, 4'd2);
      c.mem_block[1][1][2] = page_entry(SLOT_TYP_RAM, 4'd3);
      // Unpopulated RAM page over the ROM bytes
      c.mem_block[1][1][0]      = page_entry(SLOT_TYP_RAM, 4'd0);
      c.mem_block[1][1][0].init = 1'b0;
      for (int p = 0; p < 4; p++) begin
         c.mem_block[2][0][p] = page_entry(SLOT_TYP_MSX2_RAM, 4'd4);
      end
      // Cartridge image overlays the slot 1 RAM blocks
      c.cart_base    = 17'h08000;
      c.load_base[0] = 17'h00000;
      c.load_base[1] = 17'h08000;
      return c;
   endfunction

   function automatic cpu_bus_t cpu_cycle(logic [15:0] addr, logic [7:0] data,
                                          logic rd, logic wr, logic io);
      cpu_bus_t b;
      b.addr = addr;
      b.dout = data;
      b.rd   = rd;
      b.wr   = wr;
      b.mreq = !io;
      b.iorq = io;
      return b;
   endfunction

   function automatic ioctl_t host_word(logic dl, logic [7:0] index, int addr,
                                        logic [7:0] data, logic wr);
      ioctl_t w;
      w.download = dl;
      w.index    = index;
      w.addr     = 27'(addr);
      w.dout     = data;
      w.wr       = wr;
      return w;
   endfunction

   // Offset bits above 7 fold into the byte, so each 8 KB bank differs
   function automatic logic [7:0] cart_byte(logic [14:0] a);
      return a[7:0] ^ {a[14:8], 1'b0};
   endfunction

   // Page 2 gets the chosen subslot, other pages a fixed pattern
   function automatic logic [7:0] subslot_sel(logic [1:0] sub);
      return {2'b11, sub, 2'b10, 2'b01};
   endfunction

   task automatic check_val(string name, logic [7:0] expected, logic [7:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("error %s expected %02h actual %02h", name, expected, actual);
      end
   endtask

   task automatic select_slot(logic [1:0] s);
      @(posedge clk);
      active_slot <= s;
   endtask

   task automatic bus_write(logic [15:0] addr, logic [7:0] data, logic io);
      @(posedge clk);
      cpu <= cpu_cycle(addr, data, 1'b0, 1'b1, io);
      @(posedge clk);
      cpu <= '0;
   endtask

   task automatic mem_read(logic [15:0] addr, output logic [7:0] data);
      @(posedge clk);
      cpu <= cpu_cycle(addr, 8'h00, 1'b1, 1'b0, 1'b0);
      @(posedge clk);
      cpu <= '0;
      @(negedge clk);
      data = cpu_din;
   endtask

   // FFFF and the mapper ports answer in the same cycle
   task automatic reg_read(logic [15:0] addr, logic io, output logic [7:0] data);
      @(posedge clk);
      cpu <= cpu_cycle(addr, 8'h00, 1'b1, 1'b0, io);
      @(negedge clk);
      data = cpu_din;
      @(posedge clk);
      cpu <= '0;
   endtask

   task automatic load_image(logic [7:0] index, int start);
      @(posedge clk);
      ioctl <= host_word(1'b1, index, 0, 8'h00, 1'b0);
      foreach (img[i]) begin
         @(posedge clk);
         ioctl <= host_word(1'b1, index, start + i, img[i], 1'b1);
      end
      @(posedge clk);
      ioctl <= host_word(1'b1, index, 0, 8'h00, 1'b0);
   endtask

   task automatic end_download();
      @(posedge clk);
      ioctl <= '0;
      @(posedge clk);
      @(negedge clk);
   endtask

   task automatic rom_test();
      logic [7:0] d;
      img.delete();
      for (int i = 0; i < ROM_BYTES; i++) begin
         rom_img[i] = 8'($urandom);
         img.push_back(rom_img[i]);
      end
      select_slot(2'd0);
      load_image(8'd0, ROM_START);
      @(negedge clk);
      check_val("rom_need_reset_early", 8'd0, 8'(need_reset));
      end_download();
      check_val("rom_need_reset", 8'd1, 8'(need_reset));
      for (int i = 0; i < ROM_BYTES; i++) begin
         mem_read(16'(ROM_START + i), d);
         check_val("rom_read", rom_img[i], d);
      end
      bus_write(16'(ROM_START + 5), ~rom_img[5], 1'b0);
      mem_read(16'(ROM_START + 5), d);
      check_val("rom_write_protect", rom_img[5], d);
   endtask

   task automatic subslot_test();
      logic [7:0] d;
      logic [7:0] a_val;
      a_val = 8'($urandom);
      select_slot(2'd1);
      bus_write(16'hFFFF, subslot_sel(2'd1), 1'b0);
      reg_read(16'hFFFF, 1'b0, d);
      check_val("subslot_readback", ~subslot_sel(2'd1), d);
      bus_write(16'h8123, a_val, 1'b0);
      bus_write(16'hFFFF, subslot_sel(2'd0), 1'b0);
      reg_read(16'hFFFF, 1'b0, d);
      check_val("subslot_readback", ~subslot_sel(2'd0), d);
      bus_write(16'h8123, ~a_val, 1'b0);
      mem_read(16'h8123, d);
      check_val("subslot0_data", ~a_val, d);
      bus_write(16'hFFFF, subslot_sel(2'd1), 1'b0);
      mem_read(16'h8123, d);
      check_val("subslot1_data", a_val, d);
      bus_write(16'hFFFF, subslot_sel(2'd0), 1'b0);
      mem_read(16'h8123, d);
      check_val("subslot0_again", ~a_val, d);
   endtask

   task automatic mapper_test();
      logic [7:0] d;
      logic [7:0] val;
      select_slot(2'd2);
      for (int i = 0; i < 4; i++) begin
         reg_read(16'(252 + i), 1'b1, d);
         check_val("mapper_reset", {6'h3F, 2'(3 - i)}, d);
      end
      for (int i = 0; i < 4; i++) begin
         bus_write(16'(252 + i), 8'(i ^ 1), 1'b1);
         reg_read(16'(252 + i), 1'b1, d);
         check_val("mapper_readback", {6'h3F, 2'(i ^ 1)}, d);
      end
      // Write through page 2, read the same bank through page 0
      for (int k = 0; k < 4; k++) begin
         val = 8'($urandom);
         bus_write(16'h00FE, 8'(k), 1'b1);
         bus_write(16'h8000 + 16'(k * 37), val, 1'b0);
         bus_write(16'h00FC, 8'(k), 1'b1);
         mem_read(16'(k * 37), d);
         check_val("mapper_alias", val, d);
      end
   endtask

   task automatic cart_test();
      logic [7:0]  d;
      logic [7:0]  win_bank [4];
      logic [12:0] off;
      img.delete();
      for (int i = 0; i < CART_BYTES; i++) begin
         img.push_back(cart_byte(15'(i)));
      end
      load_image(8'd1, 0);
      end_download();
      select_slot(2'd3);
      for (int w = 0; w < 4; w++) begin
         win_bank[w] = 8'(3 - w);
         bus_write(16'h6000 + 16'(w) * 16'h0800, win_bank[w], 1'b0);
      end
      for (int w = 0; w < 4; w++) begin
         for (int n = 0; n < 4; n++) begin
            off = (n == 0) ? 13'h1FFF : 13'($urandom);
            mem_read(16'h4000 + 16'(w) * 16'h2000 + 16'(off), d);
            check_val("cart_window", cart_byte({win_bank[w][1:0], off}), d);
         end
      end
      mem_read(16'h0100, d);
      check_val("cart_outside", 8'hFF, d);
      mem_read(16'hC100, d);
      check_val("cart_outside", 8'hFF, d);
   endtask

   task automatic unmapped_test();
      logic [7:0] d;
      logic [7:0] v;
      v = 8'($urandom);
      select_slot(2'd0);
      mem_read(16'h8000, d);
      check_val("unmapped_read", 8'hFF, d);
      // Page 0 of subslot 1 is RAM without init and would land on the ROM bytes
      select_slot(2'd1);
      bus_write(16'hFFFF, subslot_sel(2'd0), 1'b0);
      bus_write(16'(ROM_START + 16), ~rom_img[16], 1'b0);
      mem_read(16'(ROM_START + 16), d);
      check_val("unmapped_write", 8'hFF, d);
      select_slot(2'd0);
      mem_read(16'(ROM_START + 16), d);
      check_val("unmapped_alias", rom_img[16], d);
      select_slot(2'd1);
      bus_write(16'h8200, v, 1'b0);
      @(posedge clk);
      ioctl <= host_word(1'b1, 8'd0, 0, 8'h00, 1'b0);
      bus_write(16'h8200, ~v, 1'b0);
      end_download();
      mem_read(16'h8200, d);
      check_val("download_lock", v, d);
   endtask

   initial begin
      void'($urandom(32'h3387));
      reset       = 1'b1;
      cpu         = '0;
      active_slot = 2'd0;
      ioctl       = '0;
      cfg         = build_cfg();
      errors      = 0;
      checks      = 0;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      rom_test();
      subslot_test();
      mapper_test();
      cart_test();
      unmapped_test();
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* test/tb_msx_mem_assert.sv */
`timescale 1ns/1ps

module tb_msx_mem_assert import msx_pkg::*; (
   input logic       clk,
   input logic       reset,
   input cpu_bus_t   cpu,
   input logic [7:0] cpu_din,
   input ioctl_t     ioctl,
   input logic       need_reset,
   input logic       port_we
);

   a_reset_clear: assert property (@(posedge clk) reset |-> !need_reset)
      else $error("need_reset is high while reset is asserted");

   // Read data shows up the cycle after the request
   a_read_known: assert property (@(posedge clk) disable iff (reset)
      $past(cpu.mreq && cpu.rd) |-> !$isunknown(cpu_din))
      else $error("cpu_din is unknown after a memory read");

   // Loader owns the RAM port for index 0 and 1
   a_loader_owns: assert property (@(posedge clk) disable iff (reset)
      (ioctl.download && ioctl.index[7:1] == 7'd0) |-> (port_we == ioctl.wr))
      else $error("a CPU write reached the RAM port during a download");

endmodule

bind msx_mem_top tb_msx_mem_assert assert_i (
   .clk        (clk),
   .reset      (reset),
   .cpu        (cpu),
   .cpu_din    (cpu_din),
   .ioctl      (ioctl),
   .need_reset (need_reset),
   .port_we    (msx_slots_i.dpram_i.wren_a)
);

/* verilog/cart_rom.sv */
`timescale 1ns/1ps

module cart_rom import msx_pkg::*; #(
   parameter int MEM_AW = 17
) (
   input  logic              clk,
   input  logic              reset,
   input  cpu_bus_t          cpu,
   input  logic              en,
   output logic [MEM_AW-1:0] mem_addr,
   output logic              cart_oe,
   input  logic [MEM_AW-1:0] cart_base
);

   // ASCII8 bank registers for windows 4000, 6000, 8000, A000
   logic [7:0] bank [4];
   logic       bank_wr;
   logic [1:0] bank_sel;
   logic [2:0] win_idx;
   logic [1:0] win;
   logic       in_window;

   // Register writes land in 6000-7FFF, 2 KB per register
   assign bank_wr  = en && cpu.mreq && cpu.wr && (cpu.addr[15:13] == 3'b011);
   assign bank_sel = cpu.addr[12:11];

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < 4; i++) begin
            bank[i] <= 8'(i);
         end
      end else if (bank_wr) begin
         bank[bank_sel] <= cpu.dout;
      end
   end

   // 4000 maps to window 0, A000 to window 3
   assign win_idx   = cpu.addr[15:13] - 3'd2;
   assign win       = win_idx[1:0];
   assign in_window = (cpu.addr[15:14] == 2'b01) || (cpu.addr[15:14] == 2'b10);

   assign mem_addr = cart_base + MEM_AW'({bank[win], cpu.addr[12:0]});
   assign cart_oe  = en && in_window;

endmodule

/* verilog/download.sv */
`timescale 1ns/1ps

module download import msx_pkg::*; #(
   parameter int MEM_AW = 17
) (
   input  logic                   clk,
   input  logic                   reset,
   input  ioctl_t                 ioctl,
   input  logic [1:0][MEM_AW-1:0] load_base,
   output logic [MEM_AW-1:0]      wr_addr,
   output logic [7:0]             wr_data,
   output logic                   wr_en,
   output logic                   busy,
   output logic                   need_reset
);

   logic busy_q;

   // Index 0 is system ROM, index 1 the cartridge
   assign busy    = ioctl.download && (ioctl.index[7:1] == 7'd0);
   assign wr_addr = load_base[ioctl.index[0]] + MEM_AW'(ioctl.addr);
   assign wr_data = ioctl.dout;
   assign wr_en   = busy && ioctl.wr;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         busy_q     <= 1'b0;
         need_reset <= 1'b0;
      end else begin
         busy_q <= busy;
         // End of an image, sticky until reset
         if (busy_q && !busy) begin
            need_reset <= 1'b1;
         end
      end
   end

endmodule

/* verilog/dpram.sv */
`timescale 1ns/1ps

module dpram #(
   parameter int addr_width = 17
) (
   input  logic                  clk,
   input  logic [addr_width-1:0] address_a,
   input  logic [7:0]            data_a,
   input  logic                  wren_a,
   output logic [7:0]            q_a,
   input  logic [addr_width-1:0] address_b,
   input  logic [7:0]            data_b,
   input  logic                  wren_b,
   output logic [7:0]            q_b
);

   logic [7:0] mem [2**addr_width];

   // Both ports read the old word on a write
   always_ff @(posedge clk) begin
      if (wren_a) begin
         mem[address_a] <= data_a;
      end
      if (wren_b) begin
         mem[address_b] <= data_b;
      end
      q_a <= mem[address_a];
      q_b <= mem[address_b];
   end

endmodule

/* verilog/msx2_ram_mapper.sv */
`timescale 1ns/1ps

module msx2_ram_mapper import msx_pkg::*; #(
   parameter int BANK_W = 2
) (
   input  logic              clk,
   input  logic              reset,
   input  cpu_bus_t          cpu,
   output logic [BANK_W-1:0] ram_bank,
   output logic              mapper_req,
   output logic [7:0]        mapper_dout
);

   logic [BANK_W-1:0] bank [4];
   logic              port_sel;

   // Ports FC to FF
   assign port_sel = (cpu.addr[7:2] == 6'b111111);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         // Power-on layout 3,2,1,0 for pages 0 to 3
         for (int i = 0; i < 4; i++) begin
            bank[i] <= BANK_W'(3 - i);
         end
      end else if (cpu.iorq && cpu.wr && port_sel) begin
         bank[cpu.addr[1:0]] <= cpu.dout[BANK_W-1:0];
      end
   end

   assign ram_bank   = bank[cpu.addr[15:14]];
   assign mapper_req = cpu.iorq && cpu.rd && port_sel;

   // Unused upper bits read as 1
   always_comb begin
      mapper_dout             = 8'hFF;
      mapper_dout[BANK_W-1:0] = bank[cpu.addr[1:0]];
   end

endmodule

/* verilog/msx_mem_top.sv */
`timescale 1ns/1ps

module msx_mem_top import msx_pkg::*; #(
   parameter int MEM_AW = 17,
   parameter int BANK_W = 2
) (
   input  logic       clk,
   input  logic       reset,
   input  cpu_bus_t   cpu,
   output logic [7:0] cpu_din,
   input  logic [1:0] active_slot,
   input  msx_cfg_t   cfg,
   input  ioctl_t     ioctl,
   output logic       need_reset
);

   // Configuration addresses are zero-extended into the memory space
   if (MEM_AW < CFG_AW) begin : g_aw_check
      $error("MEM_AW must be at least %0d", CFG_AW);
   end

   msx_slots #(
      .MEM_AW (MEM_AW),
      .BANK_W (BANK_W)
   ) msx_slots_i (
      .clk         (clk),
      .reset       (reset),
      .cpu         (cpu),
      .cpu_din     (cpu_din),
      .active_slot (active_slot),
      .cfg         (cfg),
      .ioctl       (ioctl),
      .need_reset  (need_reset)
   );

endmodule

/* verilog/msx_pkg.sv */
package msx_pkg;

   // Width of every address held in the configuration
   localparam int CFG_AW = 17;

   typedef enum logic [2:0] {
      SLOT_TYP_EMPTY,
      SLOT_TYP_RAM,
      SLOT_TYP_MSX2_RAM,
      SLOT_TYP_ROM,
      SLOT_TYP_CART,
      SLOT_TYP_EXPANDED
   } slot_typ_t;

   // One 16 KB page of one subslot
   typedef struct packed {
      slot_typ_t  typ;
      logic [3:0] block_id;
      logic [1:0] offset;
      logic       init;
   } block_t;

   // Static layout from the surrounding core
   typedef struct packed {
      slot_typ_t [3:0]                slot_typ;
      block_t [3:0][3:0][3:0]         mem_block;
      logic [15:0][CFG_AW-1:0]        block_base;
      logic [CFG_AW-1:0]              cart_base;
      logic [1:0][CFG_AW-1:0]         load_base;
   } msx_cfg_t;

   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  dout;
      logic        rd;
      logic        wr;
      logic        mreq;
      logic        iorq;
   } cpu_bus_t;

   // Host download port
   typedef struct packed {
      logic        download;
      logic [7:0]  index;
      logic [26:0] addr;
      logic [7:0]  dout;
      logic        wr;
   } ioctl_t;

   // FFFF register, read back as a byte or split per page
   typedef union packed {
      logic [7:0]      raw;
      logic [3:0][1:0] page;
   } subslot_reg_u;

endpackage

/* verilog/msx_slots.sv */
`timescale 1ns/1ps

module msx_slots import msx_pkg::*; #(
   parameter int MEM_AW = 17,
   parameter int BANK_W = 2
) (
   input  logic       clk,
   input  logic       reset,
   input  cpu_bus_t   cpu,
   output logic [7:0] cpu_din,
   input  logic [1:0] active_slot,
   input  msx_cfg_t   cfg,
   input  ioctl_t     ioctl,
   output logic       need_reset
);

   // Subslot selection, one register per primary slot
   subslot_reg_u subslot [4];

   slot_typ_t prim_typ;
   logic      ffff_sel;
   logic      ffff_rd;

   assign prim_typ = cfg.slot_typ[active_slot];
   assign ffff_sel = (cpu.addr == 16'hFFFF) && (prim_typ == SLOT_TYP_EXPANDED);
   assign ffff_rd  = ffff_sel && cpu.mreq && cpu.rd;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < 4; i++) begin
            subslot[i] <= '0;
         end
      end else if (ffff_sel && cpu.mreq && cpu.wr) begin
         subslot[active_slot].raw <= cpu.dout;
      end
   end

   logic [1:0] cur_page;
   logic [1:0] cur_sub;
   block_t     blk;
   slot_typ_t  typ;

   assign cur_page = cpu.addr[15:14];
   assign cur_sub  = (prim_typ == SLOT_TYP_EXPANDED) ? subslot[active_slot].page[cur_page]
                                                     : 2'd0;
   assign blk      = cfg.mem_block[active_slot][cur_sub][cur_page];
   // Plain slots carry one type for all four pages
   assign typ      = (prim_typ == SLOT_TYP_EXPANDED) ? blk.typ : prim_typ;

   logic [BANK_W-1:0] ram_bank;
   logic              mapper_req;
   logic [7:0]        mapper_dout;

   msx2_ram_mapper #(.BANK_W(BANK_W)) msx2_ram_mapper_i (
      .clk         (clk),
      .reset       (reset),
      .cpu         (cpu),
      .ram_bank    (ram_bank),
      .mapper_req  (mapper_req),
      .mapper_dout (mapper_dout)
   );

   logic [MEM_AW-1:0] cart_addr;
   logic              cart_oe;

   cart_rom #(.MEM_AW(MEM_AW)) cart_rom_i (
      .clk       (clk),
      .reset     (reset),
      .cpu       (cpu),
      .en        (typ == SLOT_TYP_CART),
      .mem_addr  (cart_addr),
      .cart_oe   (cart_oe),
      .cart_base (MEM_AW'(cfg.cart_base))
   );

   // Address formation
   logic [MEM_AW-1:0] base;
   logic [MEM_AW-1:0] mem_addr;
   logic              page_ok;

   assign base = MEM_AW'(cfg.block_base[blk.block_id]);

   always_comb begin
      page_ok  = 1'b0;
      mem_addr = base + MEM_AW'({blk.offset, cpu.addr[13:0]});
      case (typ)
         SLOT_TYP_RAM, SLOT_TYP_ROM: page_ok = blk.init;
         SLOT_TYP_MSX2_RAM: begin
            page_ok  = blk.init;
            mem_addr = base + MEM_AW'({ram_bank, cpu.addr[13:0]});
         end
         SLOT_TYP_CART: begin
            page_ok  = cart_oe;
            mem_addr = cart_addr;
         end
         default: page_ok = 1'b0;
      endcase
   end

   logic cpu_we;

   // Only writable, populated pages take CPU writes
   assign cpu_we = cpu.mreq && cpu.wr && !ffff_sel && blk.init &&
                   (typ == SLOT_TYP_RAM || typ == SLOT_TYP_MSX2_RAM);

   logic [MEM_AW-1:0] dl_addr;
   logic [7:0]        dl_data;
   logic              dl_we;
   logic              dl_busy;
   logic [1:0][MEM_AW-1:0] load_base;

   assign load_base[0] = MEM_AW'(cfg.load_base[0]);
   assign load_base[1] = MEM_AW'(cfg.load_base[1]);

   download #(.MEM_AW(MEM_AW)) download_i (
      .clk        (clk),
      .reset      (reset),
      .ioctl      (ioctl),
      .load_base  (load_base),
      .wr_addr    (dl_addr),
      .wr_data    (dl_data),
      .wr_en      (dl_we),
      .busy       (dl_busy),
      .need_reset (need_reset)
   );

   logic [7:0] ram_q;

   // Loader owns port a while busy
   dpram #(.addr_width(MEM_AW)) dpram_i (
      .clk       (clk),
      .address_a (dl_busy ? dl_addr : mem_addr),
      .data_a    (dl_busy ? dl_data : cpu.dout),
      .wren_a    (dl_busy ? dl_we : cpu_we),
      .q_a       (ram_q),
      .address_b (MEM_AW'(ioctl.addr)),
      .data_b    (ioctl.dout),
      .wren_b    (1'b0),
      .q_b       ()
   );

   logic rd_ok_q;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rd_ok_q <= 1'b0;
      end else begin
         rd_ok_q <= cpu.mreq && cpu.rd && page_ok && !ffff_sel && !dl_busy;
      end
   end

   // Register reads are combinational, RAM data arrives a cycle later
   always_comb begin
      if (ffff_rd) begin
         cpu_din = ~subslot[active_slot].raw;
      end else if (mapper_req) begin
         cpu_din = mapper_dout;
      end else if (rd_ok_q) begin
         cpu_din = ram_q;
      end else begin
         cpu_din = 8'hFF;
      end
   end

endmodule
